/* Bender.yml */
package:
  name: riscv_mem

sources:
  # packages first, then the design bottom up
  - rtl/bus_pkg.sv
  - rtl/mem_pkg.sv
  - rtl/store_align.sv
  - rtl/load_extend.sv
  - rtl/riscv2memory.sv
  - rtl/byte_sram.sv
  - rtl/riscv_mem_top.sv
  - target: test
    files:
      - verif/riscv_mem_tb.sv

/* rtl/bus_pkg.sv */
/*
  core-side load/store bus definitions
  32-bit data bus only, byte lanes of 8 bits
  size is log2 of the byte count, size 3 (double) is never legal here
  byte addresses are 16 bits, higher words wrap onto the memory
*/
package bus_pkg;

  ////////////////////
  // geometry
  ////////////////////

  // byte address width
  localparam int ADR_W = 16;
  // data width
  localparam int DAT_W = 32;
  // bits per byte lane
  localparam int BYT_W = 8;
  // number of byte lanes
  localparam int BEN_W = DAT_W / BYT_W;
  // lane offset width, log2 of BEN_W
  localparam int OFS_W = 2;

  ////////////////////
  // encodings
  ////////////////////

  // size field, 0 byte, 1 half, 2 word, 3 double
  localparam int SIZ_W = 2;

  // byte order of the core data
  typedef enum logic {
    NDN_LITTLE = 1'b0,
    NDN_BIG    = 1'b1
  } ndn_t;

  // response status
  localparam logic STS_OK  = 1'b0;
  localparam logic STS_ERR = 1'b1;

endpackage

/* rtl/byte_sram.sv */
/*
  single-port SRAM with per-byte write enables
  read data is registered, valid one cycle after the read is taken
  mem_rdt holds its last value across writes and idle cycles
  mem_rdy stays low through reset and one more cycle
*/
`timescale 1ns/10ps

module byte_sram
  import bus_pkg::*;
  import mem_pkg::*;
(
  input  logic              sub,
  input  logic              rst_n,
  input  logic              mem_vld,
  output logic              mem_rdy,
  input  logic              mem_wen,
  input  logic [MEM_AW-1:0] mem_adr,
  input  logic [BEN_W-1:0]  mem_ben,
  input  logic [DAT_W-1:0]  mem_wdt,
  output logic [DAT_W-1:0]  mem_rdt
);

  // storage array
  logic [DAT_W-1:0] mem [MEM_WORDS];
  // ready flag
  logic rdy_q;
  // handshake
  logic trn;

  ////////////////////
  // ready
  ////////////////////

  // rises on the first edge with reset released
  always_ff @(posedge sub) begin
    if (!rst_n) begin
      rdy_q <= 1'b0;
    end else begin
      rdy_q <= 1'b1;
    end
  end

  assign mem_rdy = rdy_q;
  assign trn = mem_vld & rdy_q;

  ////////////////////
  // array access
  ////////////////////

  always_ff @(posedge sub) begin
    if (trn && mem_wen) begin
      // only enabled lanes change
      for (int i = 0; i < BEN_W; i++) begin
        if (mem_ben[i]) begin
          mem[mem_adr][BYT_W*i +: BYT_W] <= mem_wdt[BYT_W*i +: BYT_W];
        end
      end
    end
    // full word read, lane selection happens in the converter
    if (trn && !mem_wen) begin
      mem_rdt <= mem[mem_adr];
    end
  end

endmodule

/* rtl/load_extend.sv */
/*
  response side of the converter, purely combinational
  inputs come from the delay stage, so they describe the request
  that produced the current read lanes
  byte order is recovered from sel, no endianness input is needed
  result is meaningless for misaligned requests
*/
`timescale 1ns/10ps

module load_extend
  import bus_pkg::*;
(
  input  logic [BEN_W-1:0]            ben,
  input  logic [BEN_W-1:0][OFS_W-1:0] sel,
  input  logic [OFS_W-1:0]            ofs,
  input  logic [SIZ_W-1:0]            siz,
  input  logic                        uns,
  input  logic [DAT_W-1:0]            lane_rdt,
  output logic [DAT_W-1:0]            rdt
);

  // byte count of the access
  int cnt;
  // highest addressed lane of the access
  logic [OFS_W-1:0] lst;
  // lane holding the most significant data byte
  logic [OFS_W-1:0] top;
  // fill bit for the upper bytes
  logic sgn;

  assign cnt = 1 << siz;
  assign lst = OFS_W'(int'(ofs) + cnt - 1);

  ////////////////////
  // sign source
  ////////////////////

  // big endian puts the top byte on the lowest lane
  // for single bytes both choices are the same lane
  assign top = (int'(sel[ofs]) == cnt - 1) ? ofs : lst;

  // zero fill for unsigned loads
  assign sgn = ~uns & lane_rdt[BYT_W*top + BYT_W - 1];

  ////////////////////
  // gather
  ////////////////////

  always_comb begin
    // upper bytes, overwritten below where a lane is enabled
    rdt = {DAT_W{sgn}};
    for (int i = 0; i < BEN_W; i++) begin
      // inverse of the store steering
      if (ben[i]) begin
        rdt[BYT_W*sel[i] +: BYT_W] = lane_rdt[BYT_W*i +: BYT_W];
      end
    end
  end

endmodule

/* rtl/mem_pkg.sv */
/*
  memory side geometry
  one word per address, word width equals the core data width
  read latency is fixed, only one cycle is supported by byte_sram
*/
package mem_pkg;

  ////////////////////
  // array size
  ////////////////////

  // number of words
  localparam int MEM_WORDS = 256;
  // word address width
  localparam int MEM_AW = 8;

  ////////////////////
  // timing
  ////////////////////

  // cycles from accepted read to valid read data
  localparam int MEM_DLY = 1;

endpackage

/* rtl/riscv2memory.sv */
/*
  core to byte-lane memory converter
  response comes MEM_DLY cycles after the handshake, the memory
  must match that latency, only MEM_DLY = 1 is in use
  no response back-pressure, the core always takes rsp_vld
  misaligned requests complete the handshake but never reach memory
*/
`timescale 1ns/10ps

module riscv2memory
  import bus_pkg::*;
  import mem_pkg::*;
(
  input  logic              sub,
  input  logic              rst_n,
  // core request
  input  logic              req_vld,
  output logic              req_rdy,
  input  logic              req_wen,
  input  logic [ADR_W-1:0]  req_adr,
  input  logic [SIZ_W-1:0]  req_siz,
  input  ndn_t              req_ndn,
  input  logic              req_uns,
  input  logic [DAT_W-1:0]  req_wdt,
  // core response
  output logic              rsp_vld,
  output logic [DAT_W-1:0]  rsp_rdt,
  output logic              rsp_sts,
  output logic              mal,
  // memory side
  output logic              mem_vld,
  input  logic              mem_rdy,
  output logic              mem_wen,
  output logic [MEM_AW-1:0] mem_adr,
  output logic [BEN_W-1:0]  mem_ben,
  output logic [DAT_W-1:0]  mem_wdt,
  input  logic [DAT_W-1:0]  mem_rdt
);

  // lane select from the request half
  logic [BEN_W-1:0][OFS_W-1:0] sel;
  // delay stage, one entry per cycle of latency
  logic [MEM_DLY-1:0]          vld_q;
  logic [MEM_DLY-1:0]          wen_q;
  logic [MEM_DLY-1:0]          mal_q;
  logic [MEM_DLY-1:0]          uns_q;
  logic [SIZ_W-1:0]            siz_q [MEM_DLY];
  logic [OFS_W-1:0]            ofs_q [MEM_DLY];
  logic [BEN_W-1:0]            ben_q [MEM_DLY];
  logic [BEN_W-1:0][OFS_W-1:0] sel_q [MEM_DLY];
  // extended load data
  logic [DAT_W-1:0]            ext_rdt;

  ////////////////////
  // request
  ////////////////////

  // stall comes only from memory
  assign req_rdy = mem_rdy;
  assign mem_vld = req_vld & ~mal;
  assign mem_wen = req_wen;
  // word address, upper bits beyond the array are dropped
  assign mem_adr = req_adr[OFS_W +: MEM_AW];

  store_align u_store (
    .adr      (req_adr),
    .siz      (req_siz),
    .ndn      (req_ndn),
    .wdt      (req_wdt),
    .mal      (mal),
    .ben      (mem_ben),
    .sel      (sel),
    .lane_wdt (mem_wdt)
  );

  ////////////////////
  // delay stage
  ////////////////////

  // control bits, cleared by reset
  always_ff @(posedge sub) begin
    if (!rst_n) begin
      vld_q <= '0;
      wen_q <= '0;
      mal_q <= '0;
    end else begin
      for (int i = MEM_DLY - 1; i > 0; i--) begin
        vld_q[i] <= vld_q[i-1];
        wen_q[i] <= wen_q[i-1];
        mal_q[i] <= mal_q[i-1];
      end
      vld_q[0] <= req_vld & req_rdy;
      wen_q[0] <= req_wen;
      mal_q[0] <= mal;
    end
  end

  // lane mapping of the request in flight
  always_ff @(posedge sub) begin
    for (int i = MEM_DLY - 1; i > 0; i--) begin
      uns_q[i] <= uns_q[i-1];
      siz_q[i] <= siz_q[i-1];
      ofs_q[i] <= ofs_q[i-1];
      ben_q[i] <= ben_q[i-1];
      sel_q[i] <= sel_q[i-1];
    end
    uns_q[0] <= req_uns;
    siz_q[0] <= req_siz;
    ofs_q[0] <= req_adr[OFS_W-1:0];
    ben_q[0] <= mem_ben;
    sel_q[0] <= sel;
  end

  ////////////////////
  // response
  ////////////////////

  load_extend u_load (
    .ben      (ben_q[MEM_DLY-1]),
    .sel      (sel_q[MEM_DLY-1]),
    .ofs      (ofs_q[MEM_DLY-1]),
    .siz      (siz_q[MEM_DLY-1]),
    .uns      (uns_q[MEM_DLY-1]),
    .lane_rdt (mem_rdt),
    .rdt      (ext_rdt)
  );

  assign rsp_vld = vld_q[MEM_DLY-1];
  assign rsp_sts = mal_q[MEM_DLY-1] ? STS_ERR : STS_OK;
  // writes and errors carry no data
  assign rsp_rdt = (wen_q[MEM_DLY-1] | mal_q[MEM_DLY-1]) ? '0 : ext_rdt;

endmodule

/* rtl/riscv_mem_top.sv */
/*
  converter in front of the byte-lane SRAM
  core sees a single request/response port with a fixed
  one-cycle response, req_rdy low right after reset
*/
`timescale 1ns/10ps

module riscv_mem_top
  import bus_pkg::*;
  import mem_pkg::*;
(
  input  logic             sub,
  input  logic             rst_n,
  // core request
  input  logic             req_vld,
  output logic             req_rdy,
  input  logic             req_wen,
  input  logic [ADR_W-1:0] req_adr,
  input  logic [SIZ_W-1:0] req_siz,
  input  ndn_t             req_ndn,
  input  logic             req_uns,
  input  logic [DAT_W-1:0] req_wdt,
  // core response
  output logic             rsp_vld,
  output logic [DAT_W-1:0] rsp_rdt,
  output logic             rsp_sts,
  output logic             mal
);

  // memory bus between converter and SRAM
  logic              mem_vld;
  logic              mem_rdy;
  logic              mem_wen;
  logic [MEM_AW-1:0] mem_adr;
  logic [BEN_W-1:0]  mem_ben;
  logic [DAT_W-1:0]  mem_wdt;
  logic [DAT_W-1:0]  mem_rdt;

  ////////////////////
  // converter
  ////////////////////

  riscv2memory u_cnv (
    .sub     (sub),
    .rst_n   (rst_n),
    .req_vld (req_vld),
    .req_rdy (req_rdy),
    .req_wen (req_wen),
    .req_adr (req_adr),
    .req_siz (req_siz),
    .req_ndn (req_ndn),
    .req_uns (req_uns),
    .req_wdt (req_wdt),
    .rsp_vld (rsp_vld),
    .rsp_rdt (rsp_rdt),
    .rsp_sts (rsp_sts),
    .mal     (mal),
    .mem_vld (mem_vld),
    .mem_rdy (mem_rdy),
    .mem_wen (mem_wen),
    .mem_adr (mem_adr),
    .mem_ben (mem_ben),
    .mem_wdt (mem_wdt),
    .mem_rdt (mem_rdt)
  );

  ////////////////////
  // memory
  ////////////////////

  byte_sram u_mem (
    .sub     (sub),
    .rst_n   (rst_n),
    .mem_vld (mem_vld),
    .mem_rdy (mem_rdy),
    .mem_wen (mem_wen),
    .mem_adr (mem_adr),
    .mem_ben (mem_ben),
    .mem_wdt (mem_wdt),
    .mem_rdt (mem_rdt)
  );

endmodule

/* rtl/store_align.sv */
/*
  request side of the converter, purely combinational
  write data comes in right aligned and leaves on the addressed lanes
  sel is also kept for the response side to undo the mapping
  lanes and sel are don't care while mal is high
*/
`timescale 1ns/10ps

module store_align
  import bus_pkg::*;
(
  input  logic [ADR_W-1:0]            adr,
  input  logic [SIZ_W-1:0]            siz,
  input  ndn_t                        ndn,
  input  logic [DAT_W-1:0]            wdt,
  output logic                        mal,
  output logic [BEN_W-1:0]            ben,
  output logic [BEN_W-1:0][OFS_W-1:0] sel,
  output logic [DAT_W-1:0]            lane_wdt
);

  // lane offset and byte count
  int ofs;
  int cnt;

  assign ofs = int'(adr[OFS_W-1:0]);
  assign cnt = 1 << siz;

  ////////////////////
  // alignment
  ////////////////////

  // low address bits must be a multiple of the size
  always_comb begin
    case (siz)
      2'd0:    mal = 1'b0;
      2'd1:    mal = adr[0];
      2'd2:    mal = |adr[1:0];
      // no double on a 32-bit bus
      default: mal = 1'b1;
    endcase
  end

  ////////////////////
  // lane steering
  ////////////////////

  always_comb begin
    for (int i = 0; i < BEN_W; i++) begin
      // lanes ofs .. ofs+cnt-1
      ben[i] = (i >= ofs) && (i < ofs + cnt);
      // source byte of wdt for lane i
      if (ndn == NDN_BIG) begin
        // msb byte lands on the lowest addressed lane
        sel[i] = OFS_W'(ofs + cnt - 1 - i);
      end else begin
        // lsb byte lands on the lowest addressed lane
        sel[i] = OFS_W'(i - ofs);
      end
      // unused lanes stay quiet
      lane_wdt[BYT_W*i +: BYT_W] = ben[i] ? wdt[BYT_W*sel[i] +: BYT_W] : '0;
    end
  end

endmodule

/* sources.f */
rtl/bus_pkg.sv
rtl/mem_pkg.sv
rtl/store_align.sv
rtl/load_extend.sv
rtl/riscv2memory.sv
rtl/byte_sram.sv
rtl/riscv_mem_top.sv
verif/riscv_mem_tb.sv

/* verif/riscv_mem_tb.sv */
/*
  testbench for the converter and byte-lane SRAM
  all traffic stays in a 16-byte window, first filled by word writes
  checks run on the falling edge, inputs change 2 ns after the rising edge
  stops at the first mismatch
*/
`timescale 1ns/10ps

module riscv_mem_tb
  import bus_pkg::*;
  import mem_pkg::*;
;

  localparam logic [15:0] BASE  = 16'h0240;
  localparam int          WIN   = 16;
  localparam int          NRND  = 400;
  localparam int          NREQ  = NRND + 8;
  localparam int          RST   = 16;
  localparam int          LIMIT = 2 * NREQ + RST + 50;

  logic sub, rst_n, req_vld, req_rdy, req_wen, req_uns;
  logic [ADR_W-1:0] req_adr;
  logic [SIZ_W-1:0] req_siz;
  ndn_t req_ndn;
  logic [DAT_W-1:0] req_wdt, rsp_rdt;
  logic rsp_vld, rsp_sts, mal;

  // reference memory for the window
  logic [7:0] ref_mem [WIN];
  // expected {sts, rdt} per accepted request
  logic [32:0] exp_q [$];
  // handshakes still inside the latency
  logic [MEM_DLY-1:0] hs_pipe = '0;
  logic [31:0] lfsr = 32'h494;
  int cyc = 0;
  int rel_cyc = 0;

  riscv_mem_top DUT (.*);

  always #20 sub = ~sub;

  ////////////////////
  // helpers
  ////////////////////

  // galois lfsr, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic logic mal_rule(input logic [15:0] adr, input logic [1:0] siz);
    return (siz == 2'd3) || ((int'(adr[1:0]) % (1 << siz)) != 0);
  endfunction

  // bytes go to adr, adr+1, ... in data order set by ndn
  function automatic void store_model(input logic [15:0] adr, input logic [1:0] siz,
                                      input logic ndn, input logic [31:0] wdt);
    int n;
    int b;
    n = 1 << siz;
    b = int'(adr - BASE);
    for (int k = 0; k < n; k++) begin
      ref_mem[b + k] = ndn ? wdt[8*(n-1-k) +: 8] : wdt[8*k +: 8];
    end
  endfunction

  function automatic logic [31:0] load_model(input logic [15:0] adr, input logic [1:0] siz,
                                             input logic ndn, input logic uns);
    int n;
    int b;
    logic [31:0] v;
    n = 1 << siz;
    b = int'(adr - BASE);
    v = '0;
    for (int k = 0; k < n; k++) begin
      if (ndn) v[8*(n-1-k) +: 8] = ref_mem[b + k];
      else v[8*k +: 8] = ref_mem[b + k];
    end
    // fill from the top bit of the loaded value
    if (!uns && v[8*n-1]) begin
      for (int i = 8 * n; i < 32; i++) v[i] = 1'b1;
    end
    return v;
  endfunction

  task automatic stop_run();
    $display("Some tests failed");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic report_value(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
    $display("FAIL %s expected 0x%h actual 0x%h", name, exp, act);
    stop_run();
  endtask

  // hold the request until req_rdy, leave 2 ns after the taking edge
  task automatic send(input logic wen, input logic [15:0] adr, input logic [1:0] siz,
                      input logic ndn, input logic uns, input logic [31:0] wdt);
    req_vld = 1'b1;
    req_wen = wen;
    req_adr = adr;
    req_siz = siz;
    req_ndn = ndn_t'(ndn);
    req_uns = uns;
    req_wdt = wdt;
    @(negedge sub);
    while (!req_rdy) @(negedge sub);
    @(posedge sub);
    #2;
    req_vld = 1'b0;
  endtask

  ////////////////////
  // checking
  ////////////////////

  // cycle count, reset release and timeout
  always @(posedge sub) begin
    cyc++;
    if (rst_n) rel_cyc++;
    if (cyc >= LIMIT) begin
      $display("timeout, responses did not arrive within %0d cycles", LIMIT);
      stop_run();
    end
  end

  always @(negedge sub) begin : check_model
    logic hs;
    logic [32:0] exp;
    hs = rst_n && req_vld && req_rdy;
    if (cyc > 0) begin
      // ready low through reset and the first released edge
      if (!rst_n || rel_cyc == 0)
        assert (req_rdy == 1'b0) else report_value("req_rdy", 0, req_rdy);
      else
        assert (req_rdy == 1'b1) else report_value("req_rdy", 1, req_rdy);
      assert (rsp_vld == hs_pipe[MEM_DLY-1])
        else report_value("rsp_vld", hs_pipe[MEM_DLY-1], rsp_vld);
      if (rsp_vld) begin
        exp = exp_q.pop_front();
        assert (rsp_sts == exp[32]) else report_value("rsp_sts", exp[32], rsp_sts);
        assert (rsp_rdt == exp[31:0]) else report_value("rsp_rdt", exp[31:0], rsp_rdt);
      end
      if (rst_n && req_vld)
        assert (mal == mal_rule(req_adr, req_siz))
          else report_value("mal", mal_rule(req_adr, req_siz), mal);
    end
    // expected response of the request taken at the next edge
    if (hs) begin
      if (mal_rule(req_adr, req_siz)) begin
        exp = {STS_ERR, 32'h0};
      end else if (req_wen) begin
        store_model(req_adr, req_siz, req_ndn, req_wdt);
        exp = {STS_OK, 32'h0};
      end else begin
        exp = {STS_OK, load_model(req_adr, req_siz, req_ndn, req_uns)};
      end
      exp_q.push_back(exp);
    end
    for (int i = MEM_DLY - 1; i > 0; i--) hs_pipe[i] = hs_pipe[i-1];
    hs_pipe[0] = hs;
  end

  ////////////////////
  // stimulus
  ////////////////////

  initial begin
    logic w, e, u, aln, gap;
    logic [1:0] s;
    logic [3:0] ofs, mask;
    sub = 1'b0;
    rst_n = 1'b0;
    req_vld = 1'b0;
    req_wen = 1'b0;
    req_adr = '0;
    req_siz = '0;
    req_ndn = NDN_LITTLE;
    req_uns = 1'b0;
    req_wdt = '0;
    repeat (RST) @(posedge sub);
    #2;
    rst_n = 1'b1;
    // fill the window, first request meets req_rdy low
    for (int i = 0; i < WIN; i += 4) send(1'b1, BASE + 16'(i), 2'd2, 1'b0, 1'b0, rand_bits(32));
    // mixed traffic, about half the gaps are zero
    for (int r = 0; r < NRND; r++) begin
      w = 1'(rand_bits(1));
      s = 2'(rand_bits(2));
      e = 1'(rand_bits(1));
      u = 1'(rand_bits(1));
      aln = 1'(rand_bits(1));
      ofs = 4'(rand_bits(4));
      mask = 4'((1 << s) - 1);
      if (aln) ofs = ofs & ~mask;
      send(w, BASE + 16'(ofs), s, e, u, rand_bits(32));
      gap = 1'(rand_bits(1));
      if (gap) begin
        @(posedge sub);
        #2;
      end
    end
    // final sweep shows that errors left memory alone
    for (int i = 0; i < WIN; i += 4) send(1'b0, BASE + 16'(i), 2'd2, 1'b0, 1'b0, '0);
    repeat (MEM_DLY + 1) @(negedge sub);
    $display("All tests passed");
    $finish;
  end

endmodule
